// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = vidTimingTb
FILELIST = vidTiming.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Test failures found" $(LOG); then \
		exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== hdl/frameCtrl.sv ====
`timescale 1ns/1ps
`include "vidTiming_defs.svh"

module frameCtrl
    import vidTimingPkg::*;
(
    input  logic      iClk,
    input  logic      rstN,
    input  logic      iStart,       // strobe
    input  logic      iStop,        // strobe, honoured at frame end
    input  pattern_t  iPattern,     // level, sampled on fe
    input  logic      fe,
    input  logic      fvde,
    output logic      pixReq,
    output logic      frameStart,
    output pattern_t  pattern,
    output frameCnt_t frameCnt,
    output logic      running
);

    ctrlState_t state, stateNxt;
    logic       stopPend;   // stop seen, waiting for fe
    logic       newFrame;   // fe that opens another frame

    // --------------------
    // next state
    // --------------------
    always_comb
    begin
        stateNxt = state;
        newFrame = 1'b0;
        case (state)
            IDLE:
                if (iStart)
                    stateNxt = ARMED;
            ARMED, RUN:
                if (fe)
                begin
                    if (stopPend || iStop)
                        stateNxt = IDLE;    // frame already complete
                    else
                    begin
                        stateNxt = RUN;
                        newFrame = 1'b1;
                    end
                end
            default:
                stateNxt = IDLE;
        endcase
    end

    always_ff @(posedge iClk)
    begin
        if (!rstN)
        begin
            state      <= IDLE;
            stopPend   <= 1'b0;
            pattern    <= PAT_BARS;
            frameCnt   <= '0;
            frameStart <= 1'b0;
        end
        else
        begin
            state      <= stateNxt;
            frameStart <= newFrame;
            if (state == IDLE)
                stopPend <= 1'b0;
            else if (iStop)
                stopPend <= 1'b1;
            else if (iStart)
                stopPend <= 1'b0;   // restart cancels a pending stop
            if (newFrame)
            begin
                pattern  <= iPattern;           // held for the whole frame
                frameCnt <= frameCnt + 1'b1;
            end
        end
    end

    assign running = (state == RUN);
    assign pixReq  = fvde && (state == RUN);    // requests only while streaming

endmodule

// ==== hdl/hVSyncGen.sv ====
`timescale 1ns/1ps
`include "vidTiming_defs.svh"

module hVSyncGen
    import vidTimingPkg::*;
(
    input  logic iClk,
    input  logic rstN,
    output logic hSync,     // horizontal sync, active high
    output logic vSync,     // vertical sync, active high
    output logic vde,       // display enable
    output logic fvde,      // early enable, PREFETCH clocks ahead of vde
    output logic fe         // frame end strobe
);

    // derived constants
    localparam int hSyncStart = `H_DISPLAY + `H_FRONT;
    localparam int hSyncEnd   = hSyncStart + `H_PULSE - 1;
    localparam int hMax       = `H_DISPLAY + `H_FRONT + `H_PULSE + `H_BACK - 1;
    localparam int vSyncStart = `V_DISPLAY + `V_FRONT;
    localparam int vSyncEnd   = vSyncStart + `V_PULSE - 1;
    localparam int vMax       = `V_DISPLAY + `V_FRONT + `V_PULSE + `V_BACK - 1;

    hPos_t hPos;        // display position
    vPos_t vPos;
    hPos_t fhPos;       // prefetch position, leads hPos
    vPos_t fvPos;

    logic hMatch, hRange;
    logic vMatch, vRange;
    logic vdeNxt, feNxt;
    logic fhMatch, fvMatch, fvdeNxt;

    // --------------------
    // display counters
    // --------------------
    always_ff @(posedge iClk)
    begin
        if (!rstN)
        begin
            hPos <= '0;
            vPos <= '0;
        end
        else if (hMatch)
        begin
            hPos <= '0;
            vPos <= vMatch ? vPos_t'(0) : vPos + 1'b1;   // next line
        end
        else
            hPos <= hPos + 1'b1;
    end

    // --------------------
    // prefetch counters
    // --------------------
    always_ff @(posedge iClk)
    begin
        if (!rstN)
        begin
            fhPos <= hPos_t'(`PREFETCH);    // start ahead by the lead
            fvPos <= '0;
        end
        else if (fhMatch)
        begin
            fhPos <= '0;
            fvPos <= fvMatch ? vPos_t'(0) : fvPos + 1'b1;
        end
        else
            fhPos <= fhPos + 1'b1;
    end

    // range decode
    always_comb
    begin
        hMatch  = (hPos == hPos_t'(hMax));
        vMatch  = (vPos == vPos_t'(vMax));
        hRange  = (hPos >= hPos_t'(hSyncStart)) && (hPos <= hPos_t'(hSyncEnd));
        vRange  = (vPos >= vPos_t'(vSyncStart)) && (vPos <= vPos_t'(vSyncEnd));
        vdeNxt  = (hPos < hPos_t'(`H_DISPLAY)) && (vPos < vPos_t'(`V_DISPLAY));
        // first blank pixel of first blank line
        feNxt   = (hPos == hPos_t'(`H_DISPLAY)) && (vPos == vPos_t'(`V_DISPLAY));
        fhMatch = (fhPos == hPos_t'(hMax));
        fvMatch = (fvPos == vPos_t'(vMax));
        fvdeNxt = (fhPos < hPos_t'(`H_DISPLAY)) && (fvPos < vPos_t'(`V_DISPLAY));
    end

    // --------------------
    // output registers
    // --------------------
    always_ff @(posedge iClk)
    begin
        if (!rstN)
        begin
            hSync <= 1'b0;
            vSync <= 1'b0;
            vde   <= 1'b0;
            fvde  <= 1'b0;
            fe    <= 1'b0;
        end
        else
        begin
            hSync <= hRange;
            vSync <= vRange;
            vde   <= vdeNxt;
            fvde  <= fvdeNxt;
            fe    <= feNxt;     // single clock, counters move on
        end
    end

endmodule

// ==== hdl/patternGen.sv ====
`timescale 1ns/1ps
`include "vidTiming_defs.svh"

module patternGen
    import vidTimingPkg::*;
(
    input  logic      iClk,
    input  logic      rstN,
    input  logic      pixReq,
    input  logic      frameStart,
    input  pattern_t  pattern,
    input  frameCnt_t frameCnt,
    output logic      wrEn,
    output pixel_t    pixel
);

    localparam int chW = `PIX_W / 3;   // bits per colour channel

    hPos_t         x;           // prefetch column
    vPos_t         y;           // prefetch line
    logic [2:0]    barIdx;
    logic [chW-1:0] r, g, b;

    // --------------------
    // prefetch position
    // --------------------
    always_ff @(posedge iClk)
    begin
        if (!rstN || frameStart)
        begin
            x <= '0;
            y <= '0;
        end
        else if (pixReq)
        begin
            if (x == hPos_t'(`H_DISPLAY - 1))
            begin
                x <= '0;
                y <= y + 1'b1;      // line wrap
            end
            else
                x <= x + 1'b1;
        end
    end

    // --------------------
    // pattern select
    // --------------------
    always_comb
    begin
        barIdx = 3'((32'(x) * 8) / `H_DISPLAY);   // eight equal bars
        r = '0;
        g = '0;
        b = '0;
        case (pattern)
            PAT_BARS:
            begin
                r = {chW{barIdx[2]}};
                g = {chW{barIdx[1]}};
                b = {chW{barIdx[0]}};
            end
            PAT_RAMP:
            begin
                r = x[chW-1:0];
                g = x[chW-1:0];
                b = x[chW-1:0];
            end
            PAT_CHECKER:
            begin
                r = {chW{x[2] ^ y[2]}};     // 4x4 squares
                g = {chW{x[2] ^ y[2]}};
                b = {chW{x[2] ^ y[2]}};
            end
            default:
            begin
                r = frameCnt[chW-1:0];      // tint moves each frame
                g = y[chW-1:0];
            end
        endcase
    end

    always_ff @(posedge iClk)
    begin
        if (!rstN)
            wrEn <= 1'b0;
        else
            wrEn <= pixReq;     // one pixel per request
    end

    always_ff @(posedge iClk)
    begin
        if (pixReq)
            pixel <= {r, g, b};
    end

endmodule

// ==== hdl/pixelFifo.sv ====
`timescale 1ns/1ps
`include "vidTiming_defs.svh"

module pixelFifo
    import vidTimingPkg::*;
(
    input  logic   iClk,
    input  logic   rstN,
    input  logic   wrEn,
    input  pixel_t wrPixel,
    input  logic   vde,
    input  logic   hSync,
    input  logic   vSync,
    input  logic   running,
    output logic   oDe,
    output pixel_t oRgb,
    output logic   oHSync,
    output logic   oVSync
);

    localparam int addrW = $clog2(`FIFO_DEPTH);

    pixel_t         mem [`FIFO_DEPTH];
    logic [addrW:0] wrPtr;      // extra msb tells full from empty
    logic [addrW:0] rdPtr;
    logic           pop;

    assign pop = vde && running;    // display pulls one pixel per active clock

    // --------------------
    // buffer
    // --------------------
    always_ff @(posedge iClk)
    begin
        if (wrEn)
            mem[wrPtr[addrW-1:0]] <= wrPixel;
    end

    always_ff @(posedge iClk)
    begin
        if (!rstN)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
        end
        else
        begin
            if (wrEn)
                wrPtr <= wrPtr + 1'b1;
            if (pop)
                rdPtr <= rdPtr + 1'b1;
        end
    end

    // --------------------
    // output stage
    // --------------------
    always_ff @(posedge iClk)
    begin
        if (!rstN)
        begin
            oDe    <= 1'b0;
            oRgb   <= '0;
            oHSync <= 1'b0;
            oVSync <= 1'b0;
        end
        else
        begin
            oDe    <= pop;
            oRgb   <= pop ? mem[rdPtr[addrW-1:0]] : pixel_t'(0);   // black when idle
            oHSync <= hSync;    // same delay as the pixel
            oVSync <= vSync;
        end
    end

endmodule

// ==== hdl/vidTimingPkg.sv ====
`include "vidTiming_defs.svh"

package vidTimingPkg;

    // --------------------
    // counter and data widths
    // --------------------
    typedef logic [5:0]        hPos_t;      // 0..24 horizontal
    typedef logic [4:0]        vPos_t;      // 0..13 vertical
    typedef logic [`PIX_W-1:0] pixel_t;     // r in top nibble, then g, b
    typedef logic [1:0]        pattern_t;
    typedef logic [7:0]        frameCnt_t;

    // pattern select codes
    localparam pattern_t PAT_BARS    = 2'd0;
    localparam pattern_t PAT_RAMP    = 2'd1;
    localparam pattern_t PAT_CHECKER = 2'd2;
    localparam pattern_t PAT_TINT    = 2'd3;

    // start/stop control
    typedef enum logic [1:0] {
        IDLE,       // no output
        ARMED,      // waiting for frame end
        RUN         // streaming pixels
    } ctrlState_t;

endpackage

// ==== hdl/vidTimingTop.sv ====
`timescale 1ns/1ps
`include "vidTiming_defs.svh"

module vidTimingTop
    import vidTimingPkg::*;
(
    input  logic      iClk,
    input  logic      rstN,
    input  logic      iStart,
    input  logic      iStop,
    input  pattern_t  iPattern,
    output logic      oHSync,
    output logic      oVSync,
    output logic      oDe,
    output pixel_t    oRgb,
    output frameCnt_t oFrameCnt,
    output logic      oRunning
);

    logic     hSync, vSync, vde, fvde, fe;
    logic     pixReq, frameStart, running;
    logic     wrEn;
    pixel_t   pixel;
    pattern_t pattern;

    // free running timing
    hVSyncGen uSync (
        .iClk  (iClk),
        .rstN  (rstN),
        .hSync (hSync),
        .vSync (vSync),
        .vde   (vde),
        .fvde  (fvde),
        .fe    (fe)
    );

    frameCtrl uCtrl (
        .iClk       (iClk),
        .rstN       (rstN),
        .iStart     (iStart),
        .iStop      (iStop),
        .iPattern   (iPattern),
        .fe         (fe),
        .fvde       (fvde),
        .pixReq     (pixReq),
        .frameStart (frameStart),
        .pattern    (pattern),
        .frameCnt   (oFrameCnt),
        .running    (running)
    );

    patternGen uPat (
        .iClk       (iClk),
        .rstN       (rstN),
        .pixReq     (pixReq),
        .frameStart (frameStart),
        .pattern    (pattern),
        .frameCnt   (oFrameCnt),
        .wrEn       (wrEn),
        .pixel      (pixel)
    );

    // absorbs the prefetch lead
    pixelFifo uFifo (
        .iClk    (iClk),
        .rstN    (rstN),
        .wrEn    (wrEn),
        .wrPixel (pixel),
        .vde     (vde),
        .hSync   (hSync),
        .vSync   (vSync),
        .running (running),
        .oDe     (oDe),
        .oRgb    (oRgb),
        .oHSync  (oHSync),
        .oVSync  (oVSync)
    );

    assign oRunning = running;

endmodule

// ==== hdl/vidTiming_defs.svh ====
`ifndef VIDTIMING_DEFS_SVH
`define VIDTIMING_DEFS_SVH

// --------------------
// horizontal timing, in pixel clocks
// --------------------
`define H_DISPLAY   16      // active pixels per line
`define H_FRONT     2       // front porch
`define H_PULSE     3       // hsync width
`define H_BACK      4       // back porch, total 25

// --------------------
// vertical timing, in lines
// --------------------
`define V_DISPLAY   8       // active lines
`define V_FRONT     2
`define V_PULSE     2       // vsync lines
`define V_BACK      2       // total 14 lines

// --------------------
// pixel path
// --------------------
`define PIX_W       12      // rgb444
`define FIFO_DEPTH  4       // covers the prefetch lead
`define PREFETCH    2       // fvde lead over vde, clocks

`endif

// ==== verif/vidTimingTb.sv ====
`timescale 1ns/1ps
`include "vidTiming_defs.svh"

module vidTimingTb
    import vidTimingPkg::*;
();

    localparam int clkPeriod    = 4;
    localparam int hTotal       = `H_DISPLAY + `H_FRONT + `H_PULSE + `H_BACK;
    localparam int vTotal       = `V_DISPLAY + `V_FRONT + `V_PULSE + `V_BACK;
    localparam int frameClks    = hTotal * vTotal;
    localparam int testFrames   = 18;     // reset 2, start 2, patterns 6, tint 3, mid 2, stop 3
    localparam int marginFrames = 4;

    logic      iClk;
    logic      rstN;
    logic      iStart;
    logic      iStop;
    pattern_t  iPattern;
    logic      oHSync;
    logic      oVSync;
    logic      oDe;
    pixel_t    oRgb;
    frameCnt_t oFrameCnt;
    logic      oRunning;

    int unsigned lcgState;
    int          errCount;
    int          pixChecked;
    int          framesChecked;
    string       curTest;
    int          startReqs, stopReqs;       // bumped by the tests
    int          startSeen, stopSeen;       // taken over by the monitor

    // monitor view of the stream
    logic     tbRun;
    pattern_t framePat;
    int       expCnt;
    int       px, py, pixCnt, lineCnt, pixTotal, vsRises;
    int       hsHigh, hsPeriod, vsHigh, vsPeriod;
    logic     prevDe, prevHs, prevVs, hsSeen, vsSeen;
    pixel_t   expPix;

    vidTimingTop dut0 (
        .iClk      (iClk),
        .rstN      (rstN),
        .iStart    (iStart),
        .iStop     (iStop),
        .iPattern  (iPattern),
        .oHSync    (oHSync),
        .oVSync    (oVSync),
        .oDe       (oDe),
        .oRgb      (oRgb),
        .oFrameCnt (oFrameCnt),
        .oRunning  (oRunning)
    );

    always #(clkPeriod / 2) iClk = ~iClk;

    // --------------------
    // helpers
    // --------------------
    function automatic int unsigned lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState >> 16;
    endfunction

    // expected pixel, straight from the pattern rules
    function automatic pixel_t refPixel(pattern_t pat, int x, int y, int cnt);
        int         bar;
        logic [3:0] r, g, b;
        bar = (x * 8) / `H_DISPLAY;     // eight bars across the line
        r = 4'h0;
        g = 4'h0;
        b = 4'h0;
        case (pat)
            PAT_BARS:
            begin
                r = bar[2] ? 4'hF : 4'h0;
                g = bar[1] ? 4'hF : 4'h0;
                b = bar[0] ? 4'hF : 4'h0;
            end
            PAT_RAMP:
            begin
                r = x[3:0];
                g = x[3:0];
                b = x[3:0];
            end
            PAT_CHECKER:
            begin
                r = (x[2] != y[2]) ? 4'hF : 4'h0;     // white square
                g = r;
                b = r;
            end
            default:
            begin
                r = cnt[3:0];
                g = y[3:0];
            end
        endcase
        return {r, g, b};
    endfunction

    task automatic reportMismatch(string what, int expected, int actual);
        errCount++;
        $display("** Error [%s] %s: expected 0x%0h, actual 0x%0h", curTest, what, expected, actual);
    endtask

    task automatic reportFailure(string msg);
        errCount++;
        $display("** Error [%s] %s", curTest, msg);
    endtask

    // returns on the rising edge after the n-th new vsync start
    task automatic waitFrames(int n);
        int target;
        @(posedge iClk);
        target = vsRises + n;
        while (vsRises < target)
            @(posedge iClk);
    endtask

    task automatic waitPixels(int n);
        int target;
        @(posedge iClk);
        target = pixTotal + n;
        while (pixTotal < target)
            @(posedge iClk);
    endtask

    // --------------------
    // output monitor
    // --------------------
    always @(negedge iClk)
    begin
        if (!rstN)
        begin
            tbRun = 1'b0;
            framePat = PAT_BARS;
            expCnt = 0;
            {px, py, pixCnt, lineCnt, pixTotal, vsRises} = '0;
            {hsHigh, hsPeriod, vsHigh, vsPeriod, startSeen, stopSeen} = '0;
            {prevDe, prevHs, prevVs, hsSeen, vsSeen} = '0;
        end
        else
        begin
            hsPeriod++;
            vsPeriod++;
            if (oHSync)
                hsHigh++;
            if (oVSync)
                vsHigh++;
            if (prevHs && !oHSync)
            begin
                if (hsHigh != `H_PULSE)
                    reportMismatch("hsync width", `H_PULSE, hsHigh);
                hsHigh = 0;
            end
            if (prevVs && !oVSync)
            begin
                if (vsHigh != `V_PULSE * hTotal)
                    reportMismatch("vsync width", `V_PULSE * hTotal, vsHigh);
                vsHigh = 0;
            end
            if (oHSync && !prevHs)
            begin
                if (hsSeen && hsPeriod != hTotal)
                    reportMismatch("hsync period", hTotal, hsPeriod);
                hsPeriod = 0;
                hsSeen = 1'b1;
            end
            // vsync start closes one frame and opens the next
            if (oVSync && !prevVs)
            begin
                if (vsSeen && vsPeriod != frameClks)
                    reportMismatch("vsync period", frameClks, vsPeriod);
                vsPeriod = 0;
                vsSeen = 1'b1;
                if (tbRun)
                begin
                    if (pixCnt != `H_DISPLAY * `V_DISPLAY)
                        reportMismatch("pixels per frame", `H_DISPLAY * `V_DISPLAY, pixCnt);
                    if (lineCnt != `V_DISPLAY)
                        reportMismatch("lines per frame", `V_DISPLAY, lineCnt);
                    framesChecked++;
                end
                if (startReqs != startSeen)
                begin
                    tbRun = 1'b1;       // start came before the last frame end
                    startSeen = startReqs;
                end
                if (stopReqs != stopSeen)
                begin
                    tbRun = 1'b0;
                    stopSeen = stopReqs;
                end
                if (tbRun)
                begin
                    expCnt++;
                    framePat = iPattern;    // value latched at the frame end
                end
                if (oFrameCnt !== frameCnt_t'(expCnt))
                    reportMismatch("frame count", expCnt, oFrameCnt);
                if (oRunning !== tbRun)
                    reportMismatch("running", tbRun, oRunning);
                pixCnt = 0;
                lineCnt = 0;
                vsRises++;
            end
            if (oDe)
            begin
                if (!prevDe)
                begin
                    px = 0;     // new line
                    py = lineCnt;
                    lineCnt++;
                end
                expPix = refPixel(framePat, px, py, expCnt);
                if (!tbRun)
                    reportFailure("display enable high while output is stopped");
                else if (oRgb !== expPix)
                    reportMismatch("pixel", expPix, oRgb);
                px++;
                pixCnt++;
                pixTotal++;
                pixChecked++;
            end
            else if (oRgb !== pixel_t'(0))
                reportMismatch("blank rgb", 0, oRgb);
            if (prevDe && !oDe && px != `H_DISPLAY)
                reportMismatch("line length", `H_DISPLAY, px);
            prevDe = oDe;
            prevHs = oHSync;
            prevVs = oVSync;
        end
    end

    // --------------------
    // tests, each entered just after a vsync start
    // --------------------
    task automatic testResetIdle();
        int i;
        curTest = "reset_idle";
        for (i = 0; i < frameClks; i++)
        begin
            @(negedge iClk);
            if (oRunning !== 1'b0)
                reportMismatch("running", 0, oRunning);
            if (oFrameCnt !== frameCnt_t'(0))
                reportMismatch("frame count", 0, oFrameCnt);
        end
        waitFrames(1);
    endtask

    task automatic testStart();
        curTest = "start_boundary";
        iStart <= 1'b1;
        startReqs++;
        @(posedge iClk);
        iStart <= 1'b0;
        waitFrames(1);      // armed frame, no oDe allowed
        @(negedge iClk);
        if (oRunning !== 1'b1)
            reportFailure("not running after the first frame end");
        waitFrames(1);
    endtask

    task automatic testPatterns();
        pattern_t seq [5];
        int       i;
        curTest = "pattern_content";
        seq[0] = PAT_BARS;
        seq[1] = PAT_RAMP;
        seq[2] = PAT_CHECKER;
        seq[3] = pattern_t'(lcgNext() % 4);
        seq[4] = pattern_t'(lcgNext() % 4);
        for (i = 0; i < 5; i++)
        begin
            iPattern <= seq[i];     // shown in the next frame
            waitFrames(1);
        end
        waitFrames(1);
    endtask

    task automatic testTint();
        int n;
        int cntPrev;
        curTest = "frame_tint";
        iPattern <= PAT_TINT;
        waitFrames(1);
        @(negedge iClk);
        cntPrev = expCnt;
        for (n = 0; n < 2; n++)
        begin
            waitFrames(1);
            @(negedge iClk);
            if (oFrameCnt !== frameCnt_t'(cntPrev + 1))
                reportMismatch("frame count step", cntPrev + 1, oFrameCnt);
            cntPrev = cntPrev + 1;
        end
    endtask

    task automatic testMidChange();
        curTest = "mid_frame_change";
        waitPixels(40);     // inside a tint frame
        iPattern <= PAT_BARS;
        waitFrames(1);      // tint frame must finish unchanged
        waitFrames(1);
    endtask

    task automatic testStop();
        curTest = "stop_at_frame_end";
        waitPixels(50);
        iStop <= 1'b1;
        stopReqs++;
        @(posedge iClk);
        iStop <= 1'b0;
        waitFrames(1);      // frame completes in full
        @(negedge iClk);
        if (oRunning !== 1'b0)
            reportFailure("still running after the stop frame end");
        waitFrames(2);      // syncs go on, oDe stays low
    endtask

    // --------------------
    // main sequence
    // --------------------
    initial
    begin
        iClk = 1'b0;
        rstN = 1'b0;
        iStart = 1'b0;
        iStop = 1'b0;
        iPattern = PAT_BARS;
        lcgState = 1528;
        errCount = 0;
        pixChecked = 0;
        framesChecked = 0;
        startReqs = 0;
        stopReqs = 0;
        curTest = "reset";
        repeat (4) @(posedge iClk);
        rstN <= 1'b1;
        testResetIdle();
        testStart();
        testPatterns();
        testTint();
        testMidChange();
        testStop();
        $display("pixels checked: %0d, frames checked: %0d, errors: %0d",
            pixChecked, framesChecked, errCount);
        if (errCount == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

    // watchdog
    initial
    begin
        #((testFrames + marginFrames) * frameClks * clkPeriod);
        $display("watchdog expired in test %s, the run took too long", curTest);
        $display("pixels checked: %0d, frames checked: %0d, errors: %0d",
            pixChecked, framesChecked, errCount);
        $display("Test failures found");
        $finish;
    end

endmodule

// ==== verif/vidTiming_assert.sv ====
`timescale 1ns/1ps
`include "vidTiming_defs.svh"

module vidTimingAssert
(
    input logic                          iClk,
    input logic                          rstN,
    input logic                          oDe,
    input logic                          oHSync,
    input logic                          oVSync,
    input logic                          frameStart,
    input logic [$clog2(`FIFO_DEPTH):0]  wrPtr,     // fifo write pointer
    input logic [$clog2(`FIFO_DEPTH):0]  rdPtr      // fifo read pointer
);

    logic [$clog2(`FIFO_DEPTH):0] fill;     // entries between read and write pointer

    assign fill = wrPtr - rdPtr;    // wraps with the pointers

    // --------------------
    // properties
    // --------------------
    deOutsideSync: assert property (@(posedge iClk) disable iff (!rstN)
        !(oDe && (oHSync || oVSync)))
        else $error("display enable high during a sync pulse");

    frameStartPulse: assert property (@(posedge iClk) disable iff (!rstN)
        frameStart |=> !frameStart)
        else $error("frame start pulse longer than one cycle");

    // pointer distance stays inside the buffer
    fifoInRange: assert property (@(posedge iClk) disable iff (!rstN)
        fill <= `FIFO_DEPTH)
        else $error("pixel fifo pointers overflowed or underflowed");

endmodule

bind vidTimingTop vidTimingAssert uAssert (
    .iClk       (iClk),
    .rstN       (rstN),
    .oDe        (oDe),
    .oHSync     (oHSync),
    .oVSync     (oVSync),
    .frameStart (frameStart),
    .wrPtr      (uFifo.wrPtr),
    .rdPtr      (uFifo.rdPtr)
);

// ==== vidTiming.f ====
+incdir+hdl
hdl/vidTimingPkg.sv
hdl/hVSyncGen.sv
hdl/frameCtrl.sv
hdl/patternGen.sv
hdl/pixelFifo.sv
hdl/vidTimingTop.sv
verif/vidTiming_assert.sv
verif/vidTimingTb.sv
